//--- source/rv5_pkg.sv
// widths, selector enumerations, stage record and operand bundle types
package rv5_pkg;

    // data path width
    localparam int xlen = 32;

    // register index width
    localparam int reg_addr_w = 5;

    // where an instruction takes its writeback value from
    typedef enum logic [1:0] {
        wb_none     = 2'd0,
        wb_alu_out  = 2'd1,
        wb_mem_read = 2'd2,
        wb_pc_plus4 = 2'd3
    } wb_sel_e;

    // second ALU operand source
    typedef enum logic [2:0] {
        op2_rs2   = 3'd0,
        op2_i_imm = 3'd1,
        op2_s_imm = 3'd2,
        op2_u_imm = 3'd3,
        op2_pc    = 3'd4
    } op2_sel_e;

    // forwarding source for one operand
    typedef enum logic [1:0] {
        fwd_none        = 2'd0,
        fwd_exe_alu_out = 2'd1,
        fwd_mem_out     = 2'd2,
        fwd_wb_data     = 2'd3
    } fwd_sel_e;

    // one decoded instruction as delivered by the decoder
    // imm already holds the value picked by op2_sel, pc included
    typedef struct packed {
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic                  reg_write;
        wb_sel_e               wb_sel;
        op2_sel_e              op2_sel;
        logic [xlen-1:0]       imm;
    } issue_t;

    // destination record of one pipeline stage
    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] rd;
        logic                  reg_write;
        wb_sel_e               wb_sel;
    } stage_info_t;

    // forwarding selects for the decode instruction
    typedef struct packed {
        fwd_sel_e op1_sel;
        fwd_sel_e op2_sel;
        fwd_sel_e rs2_sel;
    } fwd_ctrl_t;

    // resolved operands handed to execute
    typedef struct packed {
        logic [xlen-1:0]       op1;
        logic [xlen-1:0]       op2;
        logic [xlen-1:0]       store_data;
        logic [reg_addr_w-1:0] rd;
        logic                  reg_write;
        wb_sel_e               wb_sel;
    } operands_t;

endpackage

//--- source/stage_tracker.sv
// stage tracker with decode instruction register and exe, mem, wb destination records
`timescale 1ns/100ps

module stage_tracker (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 in_valid,
    input  rv5_pkg::issue_t      in_instr,
    input  logic                 pc_write,
    input  logic                 if_kill,
    input  logic                 dec_kill,
    output rv5_pkg::issue_t      dec_instr,
    output rv5_pkg::stage_info_t dec_info,
    output rv5_pkg::stage_info_t exe_info,
    output rv5_pkg::stage_info_t mem_info,
    output rv5_pkg::stage_info_t wb_info
);
    import rv5_pkg::*;

    logic        dec_valid;
    logic        accept;
    stage_info_t exe_next;

    // a transfer only happens while fetch is not stalled
    assign accept = in_valid && pc_write;

    // decode register, filled with a bubble on kill or an empty cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            dec_valid <= 1'b0;
            dec_instr <= '0;
        end else begin
            if (accept && !if_kill) begin
                dec_valid <= 1'b1;
                dec_instr <= in_instr;
            end else begin
                dec_valid <= 1'b0;
            end
        end
    end

    // record view of the decode instruction
    // write enable is masked so a bubble never looks like a writer
    always_comb begin
        dec_info.valid     = dec_valid;
        dec_info.rd        = dec_instr.rd;
        dec_info.reg_write = dec_valid && dec_instr.reg_write;
        dec_info.wb_sel    = dec_instr.wb_sel;
    end

    // decode moves on even during a load-use stall
    // the stalled instruction waits at fetch instead
    always_comb begin
        if (dec_kill) begin
            exe_next = '0;
        end else begin
            exe_next = dec_info;
        end
    end

    // exe to mem to wb shift, no stage ever holds
    always_ff @(posedge clock) begin
        if (reset) begin
            exe_info <= '0;
            mem_info <= '0;
            wb_info  <= '0;
        end else begin
            exe_info <= exe_next;
            mem_info <= exe_info;
            wb_info  <= mem_info;
        end
    end

    // pipeline must come out of reset empty
    assert property (@(posedge clock)
        reset |=> !(dec_info.valid || exe_info.valid || mem_info.valid || wb_info.valid))
        else $error("stage record valid in the cycle after reset");

endmodule

//--- source/hazard_detection_unit.sv
// hazard detection with load-use stall, branch kill and forwarding selects
`timescale 1ns/100ps

module hazard_detection_unit (
    input  rv5_pkg::issue_t      in_instr,
    input  rv5_pkg::issue_t      dec_instr,
    input  rv5_pkg::stage_info_t dec_info,
    input  rv5_pkg::stage_info_t exe_info,
    input  rv5_pkg::stage_info_t mem_info,
    input  rv5_pkg::stage_info_t wb_info,
    input  logic                 exe_branch_taken,
    output logic                 pc_write,
    output logic                 if_kill,
    output logic                 dec_kill,
    output rv5_pkg::fwd_ctrl_t   fwd
);
    import rv5_pkg::*;

    logic dec_load;
    logic exe_alu;
    logic mem_src;
    logic wb_src;
    logic dec_has_rs2;
    logic dec_is_store;

    // loads in decode are the only stall source
    assign dec_load = dec_info.valid && dec_info.reg_write &&
                      dec_info.wb_sel == wb_mem_read && dec_info.rd != '0;

    // only an ALU result exists in execute, a load there is still in flight
    assign exe_alu = exe_info.valid && exe_info.reg_write &&
                     exe_info.wb_sel == wb_alu_out && exe_info.rd != '0;

    // mem and wb can hand over both load and ALU results
    assign mem_src = mem_info.valid && mem_info.reg_write && mem_info.rd != '0 &&
                     (mem_info.wb_sel == wb_alu_out || mem_info.wb_sel == wb_mem_read);

    assign wb_src = wb_info.valid && wb_info.reg_write && wb_info.rd != '0 &&
                    (wb_info.wb_sel == wb_alu_out || wb_info.wb_sel == wb_mem_read);

    // stores carry rs2 on the data path, not on op2
    assign dec_has_rs2  = dec_instr.op2_sel == op2_rs2;
    assign dec_is_store = dec_instr.op2_sel == op2_s_imm;

    // taken branch wins over any stall
    // rs2 of the incoming word is compared even for I-type, no decoder at fetch
    always_comb begin
        if (exe_branch_taken) begin
            pc_write = 1'b1;
            if_kill  = 1'b1;
            dec_kill = 1'b1;
        end else if (dec_load &&
                     (dec_info.rd == in_instr.rs1 || dec_info.rd == in_instr.rs2)) begin
            pc_write = 1'b0;
            if_kill  = 1'b1;
            dec_kill = 1'b0;
        end else begin
            pc_write = 1'b1;
            if_kill  = 1'b0;
            dec_kill = 1'b0;
        end
    end

    // forwarding, youngest producer first
    always_comb begin
        fwd.op1_sel = fwd_none;
        fwd.op2_sel = fwd_none;
        fwd.rs2_sel = fwd_none;

        if (exe_alu && exe_info.rd == dec_instr.rs1) begin
            fwd.op1_sel = fwd_exe_alu_out;
        end else if (mem_src && mem_info.rd == dec_instr.rs1) begin
            fwd.op1_sel = fwd_mem_out;
        end else if (wb_src && wb_info.rd == dec_instr.rs1) begin
            fwd.op1_sel = fwd_wb_data;
        end

        // store data goes to rs2_sel, everything else to op2_sel
        if (dec_has_rs2 && exe_alu && exe_info.rd == dec_instr.rs2) begin
            fwd.op2_sel = fwd_exe_alu_out;
        end else if ((dec_has_rs2 || dec_is_store) && mem_src &&
                     mem_info.rd == dec_instr.rs2) begin
            if (dec_is_store) begin
                fwd.rs2_sel = fwd_mem_out;
            end else begin
                fwd.op2_sel = fwd_mem_out;
            end
        end else if ((dec_has_rs2 || dec_is_store) && wb_src &&
                     wb_info.rd == dec_instr.rs2) begin
            if (dec_is_store) begin
                fwd.rs2_sel = fwd_wb_data;
            end else begin
                fwd.op2_sel = fwd_wb_data;
            end
        end
    end

    // stall must always drop the word held at fetch
    // x0 reads come from the register file, never from a stage
    always_comb begin
        assert final (pc_write || if_kill)
            else $error("pc_write low without if_kill");
        assert final (dec_instr.rs1 != '0 || fwd.op1_sel == fwd_none)
            else $error("forward selected for rs1 = x0");
        assert final (dec_instr.rs2 != '0 ||
                      (fwd.op2_sel == fwd_none && fwd.rs2_sel == fwd_none))
            else $error("forward selected for rs2 = x0");
    end

endmodule

//--- source/register_file.sv
// register file, 31 writable registers with x0 tied to zero
`timescale 1ns/100ps

module register_file (
    input  logic                           clock,
    input  logic                           reset,
    input  logic [rv5_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [rv5_pkg::reg_addr_w-1:0] rs2_addr,
    output logic [rv5_pkg::xlen-1:0]       rs1_data,
    output logic [rv5_pkg::xlen-1:0]       rs2_data,
    input  rv5_pkg::stage_info_t           wb_info,
    input  logic [rv5_pkg::xlen-1:0]       wb_data
);
    import rv5_pkg::*;

    logic [xlen-1:0] regs [1:31];
    logic            wr_en;

    // writeback of a live writer, x0 writes dropped
    assign wr_en = wb_info.valid && wb_info.reg_write && wb_info.rd != '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_info.rd] <= wb_data;
        end
    end

    // no bypass here, the wb forward path covers same-cycle reads
    always_comb begin
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end else begin
            rs1_data = regs[rs1_addr];
        end
    end

    always_comb begin
        if (rs2_addr == '0) begin
            rs2_data = '0;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

//--- source/operand_forward.sv
// operand selection from register data, immediate and forwarded results
`timescale 1ns/100ps

module operand_forward (
    input  rv5_pkg::issue_t          dec_instr,
    input  logic                     dec_valid,
    input  logic [rv5_pkg::xlen-1:0] rs1_data,
    input  logic [rv5_pkg::xlen-1:0] rs2_data,
    input  logic [rv5_pkg::xlen-1:0] exe_alu_out,
    input  logic [rv5_pkg::xlen-1:0] mem_out,
    input  logic [rv5_pkg::xlen-1:0] wb_data,
    input  rv5_pkg::fwd_ctrl_t       fwd,
    output logic                     out_valid,
    output rv5_pkg::operands_t       out_operands
);
    import rv5_pkg::*;

    logic [xlen-1:0] rs2_value;

    assign out_valid = dec_valid;

    // op1 is always rs1
    always_comb begin
        case (fwd.op1_sel)
            fwd_exe_alu_out: out_operands.op1 = exe_alu_out;
            fwd_mem_out:     out_operands.op1 = mem_out;
            fwd_wb_data:     out_operands.op1 = wb_data;
            default:         out_operands.op1 = rs1_data;
        endcase
    end

    // rs2 as seen by a register-register instruction
    always_comb begin
        case (fwd.op2_sel)
            fwd_exe_alu_out: rs2_value = exe_alu_out;
            fwd_mem_out:     rs2_value = mem_out;
            fwd_wb_data:     rs2_value = wb_data;
            default:         rs2_value = rs2_data;
        endcase
    end

    // every non-rs2 code takes the immediate field, pc included
    assign out_operands.op2 = (dec_instr.op2_sel == op2_rs2) ? rs2_value : dec_instr.imm;

    // store data has its own select
    always_comb begin
        case (fwd.rs2_sel)
            fwd_mem_out: out_operands.store_data = mem_out;
            fwd_wb_data: out_operands.store_data = wb_data;
            default:     out_operands.store_data = rs2_data;
        endcase
    end

    assign out_operands.rd        = dec_instr.rd;
    assign out_operands.reg_write = dec_instr.reg_write;
    assign out_operands.wb_sel    = dec_instr.wb_sel;

endmodule

//--- source/rv5_hazard_top.sv
// decode-stage hazard and operand unit top level
`timescale 1ns/100ps

module rv5_hazard_top (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  rv5_pkg::issue_t          in_instr,
    input  logic                     exe_branch_taken,
    input  logic [rv5_pkg::xlen-1:0] exe_alu_out,
    input  logic [rv5_pkg::xlen-1:0] mem_out,
    input  logic [rv5_pkg::xlen-1:0] wb_data,
    output logic                     out_valid,
    output rv5_pkg::operands_t       out_operands
);
    import rv5_pkg::*;

    issue_t          dec_instr;
    stage_info_t     dec_info;
    stage_info_t     exe_info;
    stage_info_t     mem_info;
    stage_info_t     wb_info;
    logic            pc_write;
    logic            if_kill;
    logic            dec_kill;
    fwd_ctrl_t       fwd;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;

    // fetch is only held back by a load-use stall
    assign in_ready = pc_write;

    stage_tracker u_stage_tracker (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .pc_write  (pc_write),
        .if_kill   (if_kill),
        .dec_kill  (dec_kill),
        .dec_instr (dec_instr),
        .dec_info  (dec_info),
        .exe_info  (exe_info),
        .mem_info  (mem_info),
        .wb_info   (wb_info)
    );

    hazard_detection_unit u_hazard_detection_unit (
        .in_instr         (in_instr),
        .dec_instr        (dec_instr),
        .dec_info         (dec_info),
        .exe_info         (exe_info),
        .mem_info         (mem_info),
        .wb_info          (wb_info),
        .exe_branch_taken (exe_branch_taken),
        .pc_write         (pc_write),
        .if_kill          (if_kill),
        .dec_kill         (dec_kill),
        .fwd              (fwd)
    );

    register_file u_register_file (
        .clock    (clock),
        .reset    (reset),
        .rs1_addr (dec_instr.rs1),
        .rs2_addr (dec_instr.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_info  (wb_info),
        .wb_data  (wb_data)
    );

    operand_forward u_operand_forward (
        .dec_instr    (dec_instr),
        .dec_valid    (dec_info.valid),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .exe_alu_out  (exe_alu_out),
        .mem_out      (mem_out),
        .wb_data      (wb_data),
        .fwd          (fwd),
        .out_valid    (out_valid),
        .out_operands (out_operands)
    );

endmodule

//--- verification/rv5_hazard_tb.sv
// directed testbench for the hazard unit top level with reference model and compare tasks
`timescale 1ns/100ps

module rv5_hazard_tb;
    import rv5_pkg::*;

    logic            clock;
    logic            reset;
    logic            in_valid;
    logic            in_ready;
    issue_t          in_instr;
    logic            exe_branch_taken;
    logic [xlen-1:0] exe_alu_out;
    logic [xlen-1:0] mem_out;
    logic [xlen-1:0] wb_data;
    logic            out_valid;
    operands_t       out_operands;

    integer seed = 32'h493e_2212;
    int     errors = 0;
    int     checks = 0;
    int     errors_at_start = 0;

    // reference state: decode instruction, stage records, register values
    logic            m_dec_valid;
    issue_t          m_dec;
    stage_info_t     m_exe;
    stage_info_t     m_mem;
    stage_info_t     m_wb;
    logic [xlen-1:0] m_regs [0:31];

    rv5_hazard_top UUT (
        .clock            (clock),
        .reset            (reset),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .in_instr         (in_instr),
        .exe_branch_taken (exe_branch_taken),
        .exe_alu_out      (exe_alu_out),
        .mem_out          (mem_out),
        .wb_data          (wb_data),
        .out_valid        (out_valid),
        .out_operands     (out_operands)
    );

    always #5 clock = ~clock;

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_operands(input operands_t got, input operands_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error out_operands got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    function automatic issue_t build_instr(input logic [reg_addr_w-1:0] rs1,
                                           input logic [reg_addr_w-1:0] rs2,
                                           input logic [reg_addr_w-1:0] rd,
                                           input logic reg_write, input wb_sel_e wb_sel,
                                           input op2_sel_e op2_sel, input logic [xlen-1:0] imm);
        issue_t i;
        i.rs1       = rs1;
        i.rs2       = rs2;
        i.rd        = rd;
        i.reg_write = reg_write;
        i.wb_sel    = wb_sel;
        i.op2_sel   = op2_sel;
        i.imm       = imm;
        return i;
    endfunction

    // register-register ALU instruction
    function automatic issue_t alu_instr(input logic [reg_addr_w-1:0] rd,
                                         input logic [reg_addr_w-1:0] rs1,
                                         input logic [reg_addr_w-1:0] rs2);
        return build_instr(rs1, rs2, rd, 1'b1, wb_alu_out, op2_rs2, '0);
    endfunction

    // producer in stage s that may hand its result to register r
    function automatic logic producer_hit(input stage_info_t s, input logic [reg_addr_w-1:0] r,
                                          input logic alu_only);
        logic kind_ok;
        kind_ok = (s.wb_sel == wb_alu_out) || (!alu_only && s.wb_sel == wb_mem_read);
        return s.valid && s.reg_write && s.rd != '0 && s.rd == r && kind_ok;
    endfunction

    // youngest producer first, register file last
    function automatic logic [xlen-1:0] source_value(input logic [reg_addr_w-1:0] r,
                                                     input logic use_exe);
        if (use_exe && producer_hit(m_exe, r, 1'b1)) begin
            return exe_alu_out;
        end else if (producer_hit(m_mem, r, 1'b0)) begin
            return mem_out;
        end else if (producer_hit(m_wb, r, 1'b0)) begin
            return wb_data;
        end
        return m_regs[r];
    endfunction

    function automatic operands_t expect_operands();
        operands_t o;
        o.op1 = source_value(m_dec.rs1, 1'b1);
        if (m_dec.op2_sel == op2_rs2) begin
            o.op2 = source_value(m_dec.rs2, 1'b1);
        end else begin
            o.op2 = m_dec.imm;
        end
        // stores see mem and wb producers only
        if (m_dec.op2_sel == op2_s_imm) begin
            o.store_data = source_value(m_dec.rs2, 1'b0);
        end else begin
            o.store_data = m_regs[m_dec.rs2];
        end
        o.rd        = m_dec.rd;
        o.reg_write = m_dec.reg_write;
        o.wb_sel    = m_dec.wb_sel;
        return o;
    endfunction

    // load in decode against the word at fetch, I-type rs2 field included
    function automatic logic expect_stall(input issue_t nxt, input logic branch);
        logic load;
        load = m_dec_valid && m_dec.reg_write && m_dec.wb_sel == wb_mem_read && m_dec.rd != '0;
        return !branch && load && (m_dec.rd == nxt.rs1 || m_dec.rd == nxt.rs2);
    endfunction

    task automatic advance_model(input logic valid, input issue_t instr, input logic branch,
                                 input logic ready);
        stage_info_t dec_rec;
        if (m_wb.valid && m_wb.reg_write && m_wb.rd != '0) begin
            m_regs[m_wb.rd] = wb_data;
        end
        dec_rec.valid     = m_dec_valid;
        dec_rec.rd        = m_dec.rd;
        dec_rec.reg_write = m_dec_valid && m_dec.reg_write;
        dec_rec.wb_sel    = m_dec.wb_sel;
        m_wb  = m_mem;
        m_mem = m_exe;
        if (branch) begin
            m_exe = '0;
        end else begin
            m_exe = dec_rec;
        end
        m_dec_valid = valid && ready && !branch;
        if (m_dec_valid) begin
            m_dec = instr;
        end
    endtask

    // one clock: drive on the falling edge, check settled outputs, step the model
    task automatic run_cycle(input logic valid, input issue_t instr, input logic branch,
                             output logic accepted);
        logic exp_ready;
        @(negedge clock);
        in_valid         = valid;
        in_instr         = instr;
        exe_branch_taken = branch;
        exe_alu_out      = $random(seed);
        mem_out          = $random(seed);
        wb_data          = $random(seed);
        #2;
        exp_ready = !expect_stall(instr, branch);
        check_bit("in_ready", in_ready, exp_ready);
        check_bit("out_valid", out_valid, m_dec_valid);
        if (m_dec_valid) begin
            check_operands(out_operands, expect_operands());
        end
        accepted = valid && in_ready;
        advance_model(valid, instr, branch, exp_ready);
    endtask

    task automatic idle(input int n);
        logic acc;
        for (int i = 0; i < n; i++) begin
            run_cycle(1'b0, '0, 1'b0, acc);
        end
    endtask

    // offer one instruction until in_ready takes it
    task automatic send_instr(input issue_t instr, output int stalls);
        logic accepted;
        int   tries;
        stalls   = 0;
        tries    = 0;
        accepted = 1'b0;
        while (!accepted && tries < 8) begin
            run_cycle(1'b1, instr, 1'b0, accepted);
            if (!accepted) begin
                stalls++;
            end
            tries++;
        end
        if (!accepted) begin
            errors++;
            $display("instruction not accepted within 8 cycles, in_ready stuck low");
        end
    endtask

    task automatic send(input issue_t instr);
        int stalls;
        send_instr(instr, stalls);
    endtask

    task automatic end_test(input string name);
        $display("test %-16s finished, %0d errors", name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    task automatic test_reset_regfile();
        // first cycle also checks the empty pipeline after reset
        idle(1);
        send(alu_instr(5, 0, 0));
        send(alu_instr(6, 0, 0));
        idle(4);
        send(alu_instr(7, 5, 6));
        idle(1);
        end_test("reset_regfile");
    endtask

    task automatic test_forward_priority();
        // same rd in exe, mem and wb
        send(alu_instr(7, 1, 2));
        send(alu_instr(7, 1, 2));
        send(alu_instr(7, 1, 2));
        send(alu_instr(8, 7, 7));
        // mem beats wb
        send(alu_instr(9, 0, 0));
        send(alu_instr(9, 0, 0));
        idle(1);
        send(alu_instr(10, 9, 9));
        // wb alone
        send(alu_instr(11, 0, 0));
        idle(2);
        send(alu_instr(12, 11, 11));
        // exe only hands over ALU results, a jal link value there is skipped
        send(build_instr(0, 0, 13, 1'b1, wb_pc_plus4, op2_pc, 32'h0000_1000));
        send(alu_instr(14, 13, 13));
        // x0 writers in every stage
        send(alu_instr(0, 1, 2));
        send(alu_instr(0, 1, 2));
        send(alu_instr(0, 1, 2));
        send(alu_instr(14, 0, 0));
        idle(1);
        end_test("forward_priority");
    endtask

    task automatic test_load_use();
        int stalls;
        send(build_instr(1, 0, 15, 1'b1, wb_mem_read, op2_i_imm, 32'h0000_0010));
        send_instr(alu_instr(16, 15, 3), stalls);
        check_bit("load_use_one_stall", stalls == 1, 1'b1);
        // immediate field that matches the load rd also stalls
        send(build_instr(2, 0, 17, 1'b1, wb_mem_read, op2_i_imm, 32'h0000_0020));
        send_instr(build_instr(4, 17, 18, 1'b1, wb_alu_out, op2_i_imm, 32'h0000_0011), stalls);
        check_bit("imm_field_one_stall", stalls == 1, 1'b1);
        idle(1);
        end_test("load_use");
    endtask

    task automatic test_store_data();
        send(alu_instr(19, 0, 0));
        idle(1);
        send(build_instr(2, 19, 0, 1'b0, wb_none, op2_s_imm, 32'h0000_0044));
        send(alu_instr(20, 0, 0));
        idle(2);
        send(build_instr(3, 20, 0, 1'b0, wb_none, op2_s_imm, 32'hffff_fff8));
        idle(1);
        end_test("store_data");
    endtask

    task automatic test_branch_flush();
        logic acc;
        send(alu_instr(21, 0, 0));
        run_cycle(1'b1, alu_instr(21, 0, 0), 1'b1, acc);
        check_bit("branch_transfer", acc, 1'b1);
        // x21 must come from the register file, both writers were dropped
        send(alu_instr(22, 21, 21));
        send(alu_instr(23, 22, 1));
        idle(4);
        end_test("branch_flush");
    endtask

    initial begin
        clock            = 1'b0;
        reset            = 1'b1;
        in_valid         = 1'b0;
        in_instr         = '0;
        exe_branch_taken = 1'b0;
        exe_alu_out      = '0;
        mem_out          = '0;
        wb_data          = '0;
        m_dec_valid      = 1'b0;
        m_dec            = '0;
        m_exe            = '0;
        m_mem            = '0;
        m_wb             = '0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        test_reset_regfile();
        test_forward_priority();
        test_load_use();
        test_store_data();
        test_branch_flush();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- rv5_hazard.f
source/rv5_pkg.sv
source/stage_tracker.sv
source/hazard_detection_unit.sv
source/register_file.sv
source/operand_forward.sv
source/rv5_hazard_top.sv
verification/rv5_hazard_tb.sv
